/* core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width, one instruction or data word
`define CORE_DATA_W 32

// word address into program and data memory
`define CORE_ADDR_W 10

// register file addressing
`define CORE_REG_ADDR_W 5
`define CORE_NUM_REGS 32

// immediate field carried by i-format words
`define CORE_IMM_W 16

`endif

/* isa_pkg.sv */
`include "core_params.svh"

package isa_pkg;

    // major opcode, top six bits of every word
    typedef enum logic [5:0] {
        OP_ALU  = 6'h00,
        OP_JMP  = 6'h02,
        OP_BEQ  = 6'h04,
        OP_BNE  = 6'h05,
        OP_ADDI = 6'h08,
        OP_LW   = 6'h23,
        OP_SW   = 6'h2b
    } opcode_e;

    typedef enum logic [10:0] {
        F_SLL = 11'h000,
        F_SRL = 11'h002,
        F_ADD = 11'h020,
        F_SUB = 11'h022,
        F_AND = 11'h024,
        F_OR  = 11'h025,
        F_XOR = 11'h026,
        F_SLT = 11'h02a
    } funct_e;

    typedef struct packed {
        opcode_e                     opcode;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        funct_e                      funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                     opcode;
        logic [`CORE_REG_ADDR_W-1:0] rd;  // data source for sw, compare reg for branches
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic signed [`CORE_IMM_W-1:0] imm;
    } i_fmt_t;

    // same word seen as r-format or i-format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

/* core_pkg.sv */
package core_pkg;

    // alu function, picked by the decoder
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // when the pc leaves the sequential path
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_ALWAYS
    } br_cond_e;

    // what goes back into rd
    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_src_e;

endpackage

/* core_ctrl_if.sv */
`timescale 1ns/1ps
`include "core_params.svh"

interface core_ctrl_if;

    core_pkg::alu_op_e           alu_op;
    core_pkg::br_cond_e          br_cond;
    logic                        is_absolute;  // jump target is imm itself
    logic                        use_imm;      // alu b operand from imm
    logic [`CORE_DATA_W-1:0]     imm;          // already sign-extended
    core_pkg::wb_src_e           wb_src;
    logic                        reg_we;
    logic                        mem_we;
    logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
    logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
    logic [`CORE_REG_ADDR_W-1:0] rd_addr;

    modport decoder (
        output alu_op, br_cond, is_absolute, use_imm, imm, wb_src,
        output reg_we, mem_we, rs1_addr, rs2_addr, rd_addr
    );

    modport consumer (
        input alu_op, br_cond, is_absolute, use_imm, imm, wb_src,
        input reg_we, mem_we, rs1_addr, rs2_addr, rd_addr
    );

endinterface

/* core_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_control_unit (
    input  isa_pkg::instr_u instr_i,
    core_ctrl_if.decoder    ctrl
);

    isa_pkg::r_fmt_t r_w;
    isa_pkg::i_fmt_t i_w;

    assign r_w = instr_i.r;
    assign i_w = instr_i.i;

    always_comb begin
        // safe defaults, a no-op
        ctrl.alu_op      = core_pkg::ALU_ADD;
        ctrl.br_cond     = core_pkg::BR_NONE;
        ctrl.is_absolute = 1'b0;
        ctrl.use_imm     = 1'b0;
        ctrl.imm         = {{(`CORE_DATA_W-`CORE_IMM_W){i_w.imm[`CORE_IMM_W-1]}}, i_w.imm};
        ctrl.wb_src      = core_pkg::WB_ALU;
        ctrl.reg_we      = 1'b0;
        ctrl.mem_we      = 1'b0;
        ctrl.rs1_addr    = i_w.rs1;
        ctrl.rs2_addr    = i_w.rd;   // sw data and branch compare live in rd
        ctrl.rd_addr     = i_w.rd;

        case (i_w.opcode)
            isa_pkg::OP_ALU: begin
                ctrl.rs1_addr = r_w.rs1;
                ctrl.rs2_addr = r_w.rs2;
                ctrl.rd_addr  = r_w.rd;
                ctrl.reg_we   = 1'b1;
                case (r_w.funct)
                    isa_pkg::F_ADD: ctrl.alu_op = core_pkg::ALU_ADD;
                    isa_pkg::F_SUB: ctrl.alu_op = core_pkg::ALU_SUB;
                    isa_pkg::F_AND: ctrl.alu_op = core_pkg::ALU_AND;
                    isa_pkg::F_OR:  ctrl.alu_op = core_pkg::ALU_OR;
                    isa_pkg::F_XOR: ctrl.alu_op = core_pkg::ALU_XOR;
                    isa_pkg::F_SLT: ctrl.alu_op = core_pkg::ALU_SLT;
                    isa_pkg::F_SLL: ctrl.alu_op = core_pkg::ALU_SLL;
                    isa_pkg::F_SRL: ctrl.alu_op = core_pkg::ALU_SRL;
                    default:        ctrl.reg_we = 1'b0;  // unknown funct
                endcase
            end
            isa_pkg::OP_ADDI: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            isa_pkg::OP_LW: begin
                ctrl.use_imm = 1'b1;
                ctrl.wb_src  = core_pkg::WB_MEM;
                ctrl.reg_we  = 1'b1;
            end
            isa_pkg::OP_SW: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            isa_pkg::OP_BEQ: ctrl.br_cond = core_pkg::BR_EQ;
            isa_pkg::OP_BNE: ctrl.br_cond = core_pkg::BR_NE;
            isa_pkg::OP_JMP: begin
                ctrl.br_cond     = core_pkg::BR_ALWAYS;
                ctrl.is_absolute = 1'b1;
            end
            default: ;  // stays a no-op
        endcase
    end

endmodule
`default_nettype wire

/* core_program_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_program_counter (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   branch_taken_i,
    input  logic [`CORE_ADDR_W-1:0] branch_target_i,
    output logic [`CORE_ADDR_W-1:0] pc_o
);

    logic [`CORE_ADDR_W-1:0] pc_q;
    logic [`CORE_ADDR_W-1:0] pc_next;

    // word addressed, so sequential step is one
    always_comb begin
        if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else begin
            pc_next = pc_q + `CORE_ADDR_W'(1);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;  // fetch restarts at word 0
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule
`default_nettype wire

/* core_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_regfile (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    core_ctrl_if.consumer           ctrl,
    input  logic [`CORE_DATA_W-1:0] wb_data_i,
    output logic [`CORE_DATA_W-1:0] rs1_data_o,
    output logic [`CORE_DATA_W-1:0] rs2_data_o
);

    logic [`CORE_DATA_W-1:0] regs_q [`CORE_NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int idx = 0; idx < `CORE_NUM_REGS; idx++) begin
                regs_q[idx] <= '0;
            end
        end else if (ctrl.reg_we && (ctrl.rd_addr != '0)) begin
            regs_q[ctrl.rd_addr] <= wb_data_i;  // r0 writes dropped
        end
    end

    // async reads, r0 hard wired
    assign rs1_data_o = (ctrl.rs1_addr == '0) ? '0 : regs_q[ctrl.rs1_addr];
    assign rs2_data_o = (ctrl.rs2_addr == '0) ? '0 : regs_q[ctrl.rs2_addr];

endmodule
`default_nettype wire

/* core_execution_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_execution_unit (
    core_ctrl_if.consumer            ctrl,
    input  logic [`CORE_DATA_W-1:0]  rs1_data_i,
    input  logic [`CORE_DATA_W-1:0]  rs2_data_i,
    input  logic [`CORE_ADDR_W-1:0]  pc_i,
    input  logic [`CORE_DATA_W-1:0]  mem_rdata_i,
    output logic [`CORE_DATA_W-1:0]  wb_data_o,
    output logic [`CORE_ADDR_W-1:0]  mem_addr_o,
    output logic [`CORE_DATA_W-1:0]  mem_wdata_o,
    output logic                     mem_we_o,
    output logic                     branch_taken_o,
    output logic [`CORE_ADDR_W-1:0]  branch_target_o
);

    localparam int SHAMT_W = $clog2(`CORE_DATA_W);

    logic [`CORE_DATA_W-1:0] alu_b;
    logic [`CORE_DATA_W-1:0] alu_res;
    logic [SHAMT_W-1:0]      shamt;
    logic                    slt_res;

    assign alu_b   = ctrl.use_imm ? ctrl.imm : rs2_data_i;
    assign shamt   = alu_b[SHAMT_W-1:0];
    assign slt_res = $signed(rs1_data_i) < $signed(alu_b);

    always_comb begin
        case (ctrl.alu_op)
            core_pkg::ALU_ADD: alu_res = rs1_data_i + alu_b;
            core_pkg::ALU_SUB: alu_res = rs1_data_i - alu_b;
            core_pkg::ALU_AND: alu_res = rs1_data_i & alu_b;
            core_pkg::ALU_OR:  alu_res = rs1_data_i | alu_b;
            core_pkg::ALU_XOR: alu_res = rs1_data_i ^ alu_b;
            core_pkg::ALU_SLT: alu_res = `CORE_DATA_W'(slt_res);
            core_pkg::ALU_SLL: alu_res = rs1_data_i << shamt;
            core_pkg::ALU_SRL: alu_res = rs1_data_i >> shamt;
            default:           alu_res = rs1_data_i + alu_b;
        endcase
    end

    // load/store address is base + imm from the adder
    assign mem_addr_o  = alu_res[`CORE_ADDR_W-1:0];
    assign mem_wdata_o = rs2_data_i;
    assign mem_we_o    = ctrl.mem_we;

    assign wb_data_o = (ctrl.wb_src == core_pkg::WB_MEM) ? mem_rdata_i : alu_res;

    // branch compares rs1 against rs2, never the imm
    always_comb begin
        case (ctrl.br_cond)
            core_pkg::BR_EQ:     branch_taken_o = (rs1_data_i == rs2_data_i);
            core_pkg::BR_NE:     branch_taken_o = (rs1_data_i != rs2_data_i);
            core_pkg::BR_ALWAYS: branch_taken_o = 1'b1;
            default:             branch_taken_o = 1'b0;
        endcase
    end

    assign branch_target_o = ctrl.is_absolute ? ctrl.imm[`CORE_ADDR_W-1:0]
                                              : pc_i + ctrl.imm[`CORE_ADDR_W-1:0];

endmodule
`default_nettype wire

/* core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`CORE_DATA_W-1:0] val_mem_prog_i,
    input  logic [`CORE_DATA_W-1:0] val_mem_data_read_i,
    output logic [`CORE_ADDR_W-1:0] addr_mem_prog_o,
    output logic [`CORE_ADDR_W-1:0] addr_mem_data_o,
    output logic [`CORE_DATA_W-1:0] val_mem_data_write_o,
    output logic                    we_mem_data_o
);

    logic [`CORE_DATA_W-1:0] rs1_data;
    logic [`CORE_DATA_W-1:0] rs2_data;
    logic [`CORE_DATA_W-1:0] wb_data;
    logic                    branch_taken;
    logic [`CORE_ADDR_W-1:0] branch_target;
    logic [`CORE_ADDR_W-1:0] pc;

    core_ctrl_if u_ctrl_if ();

    core_control_unit u_control_unit (
        .instr_i (val_mem_prog_i),  // fetched word decoded this cycle
        .ctrl    (u_ctrl_if.decoder)
    );

    core_program_counter u_program_counter (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pc_o            (pc)
    );

    core_regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .ctrl       (u_ctrl_if.consumer),
        .wb_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    core_execution_unit u_execution_unit (
        .ctrl            (u_ctrl_if.consumer),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .pc_i            (pc),
        .mem_rdata_i     (val_mem_data_read_i),
        .wb_data_o       (wb_data),
        .mem_addr_o      (addr_mem_data_o),
        .mem_wdata_o     (val_mem_data_write_o),
        .mem_we_o        (we_mem_data_o),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    assign addr_mem_prog_o = pc;

endmodule
`default_nettype wire

/* tb_core.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core;

    localparam int RESET_CYCLES = 8;
    localparam int STIM_WORDS   = 128;
    localparam int MEM_WORDS    = 1 << `CORE_ADDR_W;

    logic                    clk_i;
    logic                    arst_n_i;
    logic [`CORE_DATA_W-1:0] val_mem_prog_i;
    logic [`CORE_DATA_W-1:0] val_mem_data_read_i;
    logic [`CORE_ADDR_W-1:0] addr_mem_prog_o;
    logic [`CORE_ADDR_W-1:0] addr_mem_data_o;
    logic [`CORE_DATA_W-1:0] val_mem_data_write_o;
    logic                    we_mem_data_o;

    logic [`CORE_DATA_W-1:0] stim_mem [STIM_WORDS];
    logic [`CORE_DATA_W-1:0] prog_mem [MEM_WORDS];
    logic [`CORE_DATA_W-1:0] data_mem [MEM_WORDS];

    int prog_len;
    int store_cnt;
    int store_base;   // index of the store count in stim_mem
    int stores_seen;
    int cycle_limit;
    int cycle_cnt = 0;

    core u_dut (
        .clk_i                (clk_i),
        .arst_n_i             (arst_n_i),
        .val_mem_prog_i       (val_mem_prog_i),
        .val_mem_data_read_i  (val_mem_data_read_i),
        .addr_mem_prog_o      (addr_mem_prog_o),
        .addr_mem_data_o      (addr_mem_data_o),
        .val_mem_data_write_o (val_mem_data_write_o),
        .we_mem_data_o        (we_mem_data_o)
    );

    task automatic check_value(input logic [`CORE_DATA_W-1:0] actual,
                               input logic [`CORE_DATA_W-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "store check failed");
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // memory models answer 1 ns and 2 ns after each edge
    always @(posedge clk_i) begin
        #1;
        val_mem_prog_i = prog_mem[addr_mem_prog_o];
        #1;
        val_mem_data_read_i = data_mem[addr_mem_data_o];  // prog word settled by now
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: %0d of %0d expected stores seen after %0d cycles",
                     stores_seen, store_cnt, cycle_cnt);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        arst_n_i            = 1'b0;
        val_mem_prog_i      = '0;
        val_mem_data_read_i = '0;
        stores_seen         = 0;

        $readmemh("core_stim.txt", stim_mem);
        prog_len    = stim_mem[0];
        store_base  = prog_len + 1;
        store_cnt   = stim_mem[store_base];
        cycle_limit = 4 * prog_len + RESET_CYCLES;
        if (prog_len < 1 || store_cnt < 1 || store_base + 2 * store_cnt >= STIM_WORDS) begin
            $display("the stim file core_stim.txt is missing or its word counts do not fit");
            $display(">>> FAIL");
            $fatal(1, "bad stim file");
        end

        for (int a = 0; a < MEM_WORDS; a++) begin
            prog_mem[a] = {isa_pkg::OP_JMP, 10'b0, 16'(a)};  // unused words spin in place
            data_mem[a] = 32'hd0d0_0000 ^ 32'(a);
        end
        for (int i = 0; i < prog_len; i++) begin
            prog_mem[i] = stim_mem[i + 1];
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        check_value(32'(addr_mem_prog_o), 32'h0, "pc in reset");  // fetch starts at word 0
        arst_n_i = 1'b1;

        // stores come in program order and are sampled mid-cycle
        while (stores_seen < store_cnt) begin
            @(negedge clk_i);
            if (we_mem_data_o) begin
                check_value(32'(addr_mem_data_o), stim_mem[store_base + 1 + 2 * stores_seen],
                            "store address");
                check_value(val_mem_data_write_o, stim_mem[store_base + 2 + 2 * stores_seen],
                            "store data");
                data_mem[addr_mem_data_o] = val_mem_data_write_o;
                stores_seen++;
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* core_stim.txt */
// hex words: program word count, program words, expected store count,
// then one expected store per line as address and data
22
20200005 // addi r1, r0, 5
20400003 // addi r2, r0, 3
00611020 // add  r3, r1, r2
00820822 // sub  r4, r2, r1
00a11024 // and  r5, r1, r2
00c11025 // or   r6, r1, r2
00e11026 // xor  r7, r1, r2
0104082a // slt  r8, r4, r1
01211000 // sll  r9, r1, r2
01441002 // srl  r10, r4, r2
ac600010 // sw   r3, 0x10(r0)
ac800011 // sw   r4, 0x11(r0)
aca00012 // sw   r5, 0x12(r0)
acc00013 // sw   r6, 0x13(r0)
ace00014 // sw   r7, 0x14(r0)
ad000015 // sw   r8, 0x15(r0)
ad200016 // sw   r9, 0x16(r0)
ad400017 // sw   r10, 0x17(r0)
20010007 // addi r0, r1, 7
ac000018 // sw   r0, 0x18(r0)
8d600016 // lw   r11, 0x16(r0)
216b0002 // addi r11, r11, 2
ad610020 // sw   r11, 0x20(r1)
10410002 // beq  r1, r2, +2
ac200030 // sw   r1, 0x30(r0)
10210002 // beq  r1, r1, +2
ac400031 // sw   r2, 0x31(r0)
14410002 // bne  r1, r2, +2
ac400032 // sw   r2, 0x32(r0)
ac400033 // sw   r2, 0x33(r0)
08000020 // jmp  0x20
ac200034 // sw   r1, 0x34(r0)
ac600036 // sw   r3, 0x36(r0)
08000021 // jmp  0x21
0d
010 00000008
011 fffffffe
012 00000001
013 00000007
014 00000006
015 00000001
016 00000028
017 1fffffff
018 00000000
025 0000002a
030 00000005
033 00000003
036 00000008

/* core.f */
+incdir+.
isa_pkg.sv
core_pkg.sv
core_ctrl_if.sv
core_control_unit.sv
core_program_counter.sv
core_regfile.sv
core_execution_unit.sv
core.sv
tb_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f core.f --top-module tb_core -o tb_core_sim
sim_out=$(./obj_dir/tb_core_sim 2>&1 || true)
echo "$sim_out"
echo "$sim_out" | grep -qx '>>> PASS'
